// ==== audio_mix.f ====
+incdir+design
design/audio_data_pkg.sv
design/audio_ctrl_pkg.sv
design/audio_dac.sv
design/audio_channel.sv
design/audio_mixer.sv
design/audio_top.sv
test/tb_audio_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the audio testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f audio_mix.f --top-module tb_audio_top \
    -Mdir "$BUILD_DIR" -o tb_audio_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BUILD_DIR/tb_audio_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== test/audio_tests.txt ====
# en vol0 vol1 per0 per1 start0 start1 len0 len1 word0 word1 exp_l exp_r kind (all hex)
# kind 1 idle, 2 fetch addresses, 3 mix, 4 saturation, 5 pdm density, 6 disable and restore
0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00 00 1
1 0000 0000 0002 0002 0100 0100 0003 0003 1234 5678 00 00 2
1 0000 0000 0003 0002 fffe 0040 0004 0001 9abc def0 00 00 2
1 4040 4040 0020 0020 0200 0300 0002 0002 2020 1010 b0 b0 3
1 4040 4040 0020 0020 0200 0300 0002 0002 e0e0 f0f0 50 50 3
1 7f00 007f 0020 0020 0200 0300 0002 0002 2020 d0d0 bf 20 3
1 0000 0000 0020 0020 0200 0300 0002 0002 5555 aaaa 80 80 3
1 40c0 2020 0020 0020 0200 0300 0002 0002 3030 9090 78 18 3
1 7f7f 7f7f 0020 0020 0200 0300 0002 0002 7f7f 7f7f ff ff 4
1 7f7f 7f7f 0020 0020 0200 0300 0002 0002 8080 8080 00 00 4
1 807f 807f 0020 0020 0200 0300 0002 0002 8080 8080 ff 00 4
1 4041 0000 0020 0020 0200 0300 0002 0002 7f7f 0000 ff ff 4
1 4040 4040 0020 0020 0200 0300 0002 0002 8080 0101 01 01 4
1 4020 0000 0020 0020 0200 0300 0002 0002 2020 0000 a0 90 5
1 40c0 2020 0020 0020 0200 0300 0002 0002 3030 9090 78 18 5
1 4040 4040 0020 0020 0200 0300 0002 0002 e0e0 f0f0 50 50 6
1 7f00 007f 0030 0010 0200 0300 0004 0001 2020 d0d0 bf 20 6

// ==== test/tb_audio_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "audio_defs.svh"

module tb_audio_top;

    localparam int HALF_PERIOD   = 50;
    localparam int RESET_CYCLES  = 4;
    localparam int FETCH_TIMEOUT = 2000;            // cycles for one address sequence
    localparam int RUN_LIMIT     = 200000;

    logic                       clk;
    logic                       reset_i;
    logic                       audio_enable_i;
    logic                       audio_strobe_i;
    audio_data_pkg::word_t      ch0_vol_i, ch1_vol_i;
    audio_data_pkg::word_t      ch0_period_i, ch1_period_i;
    audio_data_pkg::addr_t      ch0_start_i, ch1_start_i;
    logic [`AUDIO_LEN_W-1:0]    ch0_len_i, ch1_len_i;
    audio_data_pkg::word_t      ch0_word_i, ch1_word_i;     // memory model, any address
    logic                       ch0_fetch_o, ch1_fetch_o;
    audio_data_pkg::addr_t      ch0_addr_o, ch1_addr_o;
    audio_data_pkg::level_t     mix_l_o, mix_r_o;
    logic                       pdm_l_o, pdm_r_o;

    // fields of the current tests file line
    logic [31:0]                t_en, t_kind;
    logic [31:0]                t_vol0, t_vol1;
    logic [31:0]                t_per0, t_per1;
    logic [31:0]                t_start0, t_start1;
    logic [31:0]                t_len0, t_len1;
    logic [31:0]                t_word0, t_word1;
    logic [31:0]                t_exp_l, t_exp_r;

    audio_data_pkg::level_t     exp_l;              // levels given by the mixing rule
    audio_data_pkg::level_t     exp_r;
    integer                     seed;
    int                         strobe_phase;
    int                         cycle_cnt;
    int                         errors;
    int                         checks;

    audio_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // memory strobe on every 4th cycle, phase picked at random
    initial begin
        seed           = 32'hde0c;
        strobe_phase   = $unsigned($random(seed)) % 4;
        cycle_cnt      = 0;
        audio_strobe_i = 1'b0;
        forever begin
            @(posedge clk);
            audio_strobe_i <= (cycle_cnt % 4 == strobe_phase);
            cycle_cnt      = cycle_cnt + 1;
        end
    end

    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("run limit reached, the testbench is stuck");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // two signed products summed, shifted down by 6, clamped, then offset by 0x80
    function automatic audio_data_pkg::level_t expected_level(
        input logic [7:0] s0,
        input logic [7:0] v0,
        input logic [7:0] s1,
        input logic [7:0] v1
    );
        int a0;
        int b0;
        int a1;
        int b1;
        int total;

        a0 = {{24{s0[7]}}, s0};
        b0 = {{24{v0[7]}}, v0};
        a1 = {{24{s1[7]}}, s1};
        b1 = {{24{v1[7]}}, v1};
        total = (a0 * b0 + a1 * b1) >>> 6;
        if (total > 127) begin
            total = 127;
        end else if (total < -128) begin
            total = -128;
        end
        return 8'(total + 128);
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Fail %s: expected %h, got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic check_levels();
        check_value("mix_l_o", {8'h00, mix_l_o}, {8'h00, exp_l});
        check_value("mix_r_o", {8'h00, mix_r_o}, {8'h00, exp_r});
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_i        <= 1'b1;
        audio_enable_i <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
    endtask

    // long enough for a fetch, two sample steps and the mixer
    task automatic settle();
        int longest;

        longest = (t_per0 > t_per1) ? t_per0 : t_per1;
        repeat (3 * (longest + 2) + 20) @(negedge clk);
    endtask

    task automatic check_idle();
        repeat (20) begin
            @(negedge clk);
            check_value("ch0_fetch_o", {15'b0, ch0_fetch_o}, 16'h0000);
            check_value("ch1_fetch_o", {15'b0, ch1_fetch_o}, 16'h0000);
            check_levels();
        end
    endtask

    // accepted addresses run start .. start+len-1 and wrap, three passes
    task automatic check_fetch_sequence();
        int n0;
        int n1;
        int need0;
        int need1;
        int cnt;

        n0    = 0;
        n1    = 0;
        need0 = 3 * t_len0 + 1;
        need1 = 3 * t_len1 + 1;
        cnt   = 0;
        while ((n0 < need0 || n1 < need1) && cnt < FETCH_TIMEOUT) begin
            @(negedge clk);
            cnt++;
            if (audio_enable_i && audio_strobe_i && ch0_fetch_o && n0 < need0) begin
                check_value("ch0_addr_o", ch0_addr_o, 16'(t_start0 + n0 % t_len0));
                n0++;
            end
            if (audio_enable_i && audio_strobe_i && ch1_fetch_o && n1 < need1) begin
                check_value("ch1_addr_o", ch1_addr_o, 16'(t_start1 + n1 % t_len1));
                n1++;
            end
        end
        if (n0 < need0 || n1 < need1) begin
            errors++;
            $display("timeout: only %0d and %0d fetches accepted on the channels", n0, n1);
        end
    endtask

    task automatic check_density();
        int ones_l;
        int ones_r;
        int lvl_l;
        int lvl_r;

        ones_l = 0;
        ones_r = 0;
        lvl_l  = {24'b0, exp_l};
        lvl_r  = {24'b0, exp_r};
        repeat (256) begin
            @(negedge clk);
            ones_l += pdm_l_o;                      // pulses counted over one full wrap
            ones_r += pdm_r_o;
        end
        checks += 2;
        assert (ones_l >= lvl_l - 1 && ones_l <= lvl_l + 1) else begin
            errors++;
            $display("Fail pdm_l_o: expected %h ones, got %h", lvl_l[15:0], ones_l[15:0]);
        end
        assert (ones_r >= lvl_r - 1 && ones_r <= lvl_r + 1) else begin
            errors++;
            $display("Fail pdm_r_o: expected %h ones, got %h", lvl_r[15:0], ones_r[15:0]);
        end
    endtask

    task automatic check_disable();
        int cnt;

        @(posedge clk);
        audio_enable_i <= 1'b0;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while ((mix_l_o != 8'h00 || mix_r_o != 8'h00) && cnt < 2);
        check_value("mix_l_o", {8'h00, mix_l_o}, 16'h0000);
        check_value("mix_r_o", {8'h00, mix_r_o}, 16'h0000);
        repeat (8) @(negedge clk);
        @(posedge clk);
        audio_enable_i <= 1'b1;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while ((mix_l_o != exp_l || mix_r_o != exp_r) && cnt < 16);
        check_levels();
    endtask

    task automatic run_test();
        exp_l = expected_level(t_word0[15:8], t_vol0[15:8], t_word1[15:8], t_vol1[15:8]);
        exp_r = expected_level(t_word0[15:8], t_vol0[7:0], t_word1[15:8], t_vol1[7:0]);
        if (t_kind < 3) begin
            exp_l = 8'h00;                          // enable low or levels unused
            exp_r = 8'h00;
        end
        checks++;
        assert (t_kind < 3 || (exp_l == t_exp_l[7:0] && exp_r == t_exp_r[7:0])) else begin
            errors++;
            $display("tests file levels %h %h disagree with the mixing rule",
                     t_exp_l[7:0], t_exp_r[7:0]);
        end

        apply_reset();
        @(posedge clk);
        audio_enable_i <= t_en[0];
        ch0_vol_i      <= t_vol0[15:0];
        ch1_vol_i      <= t_vol1[15:0];
        ch0_period_i   <= t_per0[15:0];
        ch1_period_i   <= t_per1[15:0];
        ch0_start_i    <= t_start0[15:0];
        ch1_start_i    <= t_start1[15:0];
        ch0_len_i      <= t_len0[`AUDIO_LEN_W-1:0];
        ch1_len_i      <= t_len1[`AUDIO_LEN_W-1:0];
        ch0_word_i     <= t_word0[15:0];
        ch1_word_i     <= t_word1[15:0];

        case (t_kind)
            32'd1: check_idle();
            32'd2: check_fetch_sequence();
            32'd3, 32'd4: begin
                settle();
                check_levels();
            end
            32'd5: begin
                settle();
                check_levels();
                check_density();
            end
            32'd6: begin
                settle();
                check_levels();
                check_disable();
            end
            default: begin
                errors++;
                $display("unknown test kind %0d in tests file", t_kind);
            end
        endcase
    endtask

    initial begin
        int     fd;
        int     rc;
        string  line;

        errors         = 0;
        checks         = 0;
        reset_i        = 1'b1;
        audio_enable_i = 1'b0;
        ch0_vol_i      = '0;
        ch1_vol_i      = '0;
        ch0_period_i   = '0;
        ch1_period_i   = '0;
        ch0_start_i    = '0;
        ch1_start_i    = '0;
        ch0_len_i      = '0;
        ch1_len_i      = '0;
        ch0_word_i     = '0;
        ch1_word_i     = '0;

        fd = $fopen("test/audio_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open test/audio_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc   = $fgets(line, fd);
                if (rc == 0 || line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             t_en, t_vol0, t_vol1, t_per0, t_per1, t_start0, t_start1,
                             t_len0, t_len1, t_word0, t_word1, t_exp_l, t_exp_r, t_kind);
                if (rc != 14) begin
                    errors++;
                    $display("malformed line in tests file: %s", line);
                end else begin
                    run_test();
                end
            end
            $fclose(fd);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/audio_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "audio_defs.svh"

module audio_top (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       audio_enable_i,
    input  wire logic                       audio_strobe_i,     // memory data valid
    input  wire audio_data_pkg::word_t      ch0_vol_i,          // left high byte, right low byte
    input  wire audio_data_pkg::word_t      ch1_vol_i,
    input  wire audio_data_pkg::word_t      ch0_period_i,
    input  wire audio_data_pkg::word_t      ch1_period_i,
    input  wire audio_data_pkg::addr_t      ch0_start_i,
    input  wire audio_data_pkg::addr_t      ch1_start_i,
    input  wire logic [`AUDIO_LEN_W-1:0]    ch0_len_i,
    input  wire logic [`AUDIO_LEN_W-1:0]    ch1_len_i,
    input  wire audio_data_pkg::word_t      ch0_word_i,
    input  wire audio_data_pkg::word_t      ch1_word_i,
    output logic                            ch0_fetch_o,
    output logic                            ch1_fetch_o,
    output audio_data_pkg::addr_t           ch0_addr_o,
    output audio_data_pkg::addr_t           ch1_addr_o,
    output audio_data_pkg::level_t          mix_l_o,            // also feeds the left DAC
    output audio_data_pkg::level_t          mix_r_o,
    output logic                            pdm_l_o,
    output logic                            pdm_r_o
);

    audio_data_pkg::sample_t    ch0_sample;
    audio_data_pkg::sample_t    ch1_sample;

    audio_channel u_ch0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .enable_i   (audio_enable_i),
        .strobe_i   (audio_strobe_i),
        .period_i   (ch0_period_i),
        .start_i    (ch0_start_i),
        .len_i      (ch0_len_i),
        .word_i     (ch0_word_i),
        .fetch_o    (ch0_fetch_o),
        .addr_o     (ch0_addr_o),
        .sample_o   (ch0_sample)
    );

    audio_channel u_ch1 (
        .clk        (clk),
        .reset_i    (reset_i),
        .enable_i   (audio_enable_i),
        .strobe_i   (audio_strobe_i),
        .period_i   (ch1_period_i),
        .start_i    (ch1_start_i),
        .len_i      (ch1_len_i),
        .word_i     (ch1_word_i),
        .fetch_o    (ch1_fetch_o),
        .addr_o     (ch1_addr_o),
        .sample_o   (ch1_sample)
    );

    audio_mixer u_mixer (
        .clk        (clk),
        .reset_i    (reset_i),
        .enable_i   (audio_enable_i),
        .sample0_i  (ch0_sample),
        .sample1_i  (ch1_sample),
        .vol0_i     (ch0_vol_i),
        .vol1_i     (ch1_vol_i),
        .level_l_o  (mix_l_o),
        .level_r_o  (mix_r_o)
    );

    audio_dac #(
        .WIDTH      (`AUDIO_DAC_W)
    ) u_dac_l (
        .clk        (clk),
        .reset_i    (reset_i),
        .value_i    (mix_l_o),
        .pulse_o    (pdm_l_o)
    );

    audio_dac #(
        .WIDTH      (`AUDIO_DAC_W)
    ) u_dac_r (
        .clk        (clk),
        .reset_i    (reset_i),
        .value_i    (mix_r_o),
        .pulse_o    (pdm_r_o)
    );

endmodule

`default_nettype wire

// ==== design/audio_mixer.sv ====
`default_nettype none
`timescale 1ns/1ps

module audio_mixer (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       enable_i,
    input  wire audio_data_pkg::sample_t    sample0_i,
    input  wire audio_data_pkg::sample_t    sample1_i,
    input  wire audio_data_pkg::word_t      vol0_i,         // left volume high byte, right low
    input  wire audio_data_pkg::word_t      vol1_i,
    output audio_data_pkg::level_t          level_l_o,
    output audio_data_pkg::level_t          level_r_o
);

    audio_ctrl_pkg::mix_state_e     state;
    audio_data_pkg::sample_t        smp0_q;
    audio_data_pkg::sample_t        smp1_q;
    audio_data_pkg::word_t          vol0_q;
    audio_data_pkg::word_t          vol1_q;
    audio_data_pkg::level_t         mix_l;
    audio_data_pkg::level_t         mix_r;

    // one stereo side: two products, scale down, clamp, then offset binary
    function automatic audio_data_pkg::level_t mix_side(
        input audio_data_pkg::sample_t s0,
        input audio_data_pkg::sample_t v0,
        input audio_data_pkg::sample_t s1,
        input audio_data_pkg::sample_t v1
    );
        logic signed [15:0] p0;
        logic signed [15:0] p1;
        logic signed [16:0] sum;
        logic signed [10:0] scaled;
        logic signed [7:0]  clamped;

        p0     = s0 * v0;
        p1     = s1 * v1;
        sum    = p0 + p1;
        scaled = sum[16:6];                             // arithmetic shift right by 6
        if (scaled > 11'sd127) begin
            clamped = 8'sd127;
        end else if (scaled < -11'sd128) begin
            clamped = -8'sd128;
        end else begin
            clamped = scaled[7:0];
        end
        return {~clamped[7], clamped[6:0]};             // same as adding 0x80
    endfunction

    always_comb begin
        mix_l = mix_side(smp0_q, vol0_q[15:8], smp1_q, vol1_q[15:8]);
        mix_r = mix_side(smp0_q, vol0_q[7:0], smp1_q, vol1_q[7:0]);
    end

    // operands are sampled only in the capture phase
    always_ff @(posedge clk) begin
        if (enable_i && state == audio_ctrl_pkg::MIX_CAPTURE) begin
            smp0_q <= sample0_i;
            smp1_q <= sample1_i;
            vol0_q <= vol0_i;
            vol1_q <= vol1_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state     <= audio_ctrl_pkg::MIX_CAPTURE;
            level_l_o <= '0;
            level_r_o <= '0;
        end else if (!enable_i) begin
            state     <= audio_ctrl_pkg::MIX_CAPTURE;
            level_l_o <= '0;                            // unit off, DACs silent
            level_r_o <= '0;
        end else begin
            case (state)
                audio_ctrl_pkg::MIX_CAPTURE: begin
                    state <= audio_ctrl_pkg::MIX_OUTPUT;
                end
                audio_ctrl_pkg::MIX_OUTPUT: begin
                    level_l_o <= mix_l;
                    level_r_o <= mix_r;
                    state     <= audio_ctrl_pkg::MIX_CAPTURE;
                end
                default: begin
                    state <= audio_ctrl_pkg::MIX_CAPTURE;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset_i)
        state inside {audio_ctrl_pkg::MIX_CAPTURE, audio_ctrl_pkg::MIX_OUTPUT});

endmodule

`default_nettype wire

// ==== design/audio_channel.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "audio_defs.svh"

module audio_channel (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       enable_i,
    input  wire logic                       strobe_i,       // memory data valid this cycle
    input  wire audio_data_pkg::word_t      period_i,       // low 15 bits reload the countdown
    input  wire audio_data_pkg::addr_t      start_i,        // first word of the block
    input  wire logic [`AUDIO_LEN_W-1:0]    len_i,          // block length in words
    input  wire audio_data_pkg::word_t      word_i,
    output logic                            fetch_o,
    output audio_data_pkg::addr_t           addr_o,
    output audio_data_pkg::sample_t         sample_o
);

    audio_data_pkg::word_t          period_cnt;     // sample step when top bit sets
    logic [`AUDIO_LEN_W+1:0]        byte_cnt;       // bytes left, top bit flags underflow
    audio_data_pkg::word_t          word_q;         // word being played
    audio_data_pkg::word_t          cur_word;       // held word, or the one arriving now
    logic                           step;
    logic                           take_word;
    logic                           blk_end;
    logic                           restart;

    // only used by the checks below
    logic                           seen_en;
    audio_data_pkg::addr_t          start_q;
    logic [`AUDIO_LEN_W-1:0]        len_q;

    assign step      = period_cnt[`AUDIO_WORD_W-1];
    assign take_word = strobe_i & fetch_o;
    assign cur_word  = take_word ? word_i : word_q;

    // last byte of the block plays now, so the next word comes from start again
    assign blk_end = step & (byte_cnt == {{(`AUDIO_LEN_W+1){1'b0}}, 1'b1});
    assign restart = byte_cnt[`AUDIO_LEN_W+1] | blk_end;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            period_cnt <= '1;
            byte_cnt   <= '1;                       // underflow, first enable restarts
            fetch_o    <= 1'b0;
            addr_o     <= '0;
            sample_o   <= '0;
        end else if (enable_i) begin
            period_cnt <= period_cnt - 1'b1;

            if (take_word) begin
                fetch_o <= 1'b0;                    // word accepted
            end

            if (step) begin
                sample_o   <= cur_word[15:8];
                period_cnt <= {1'b0, period_i[`AUDIO_WORD_W-2:0]};
                byte_cnt   <= byte_cnt - 1'b1;
                if (byte_cnt[0]) begin              // low byte done, next word needed
                    addr_o  <= addr_o + 1'b1;
                    fetch_o <= 1'b1;
                end
            end

            if (restart) begin
                addr_o   <= start_i;
                byte_cnt <= {1'b0, len_i, 1'b0};    // two bytes per word
                fetch_o  <= 1'b1;
            end
        end
    end

    // shift the low byte up after each step
    always_ff @(posedge clk) begin
        if (enable_i) begin
            if (step) begin
                word_q <= {cur_word[7:0], cur_word[7:0]};
            end else if (take_word) begin
                word_q <= word_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            seen_en <= 1'b0;
        end else if (enable_i) begin
            seen_en <= 1'b1;
        end
    end

    // block settings in force at the last restart
    always_ff @(posedge clk) begin
        if (enable_i && restart) begin
            start_q <= start_i;
            len_q   <= len_i;
        end
    end

    // a channel that has never run asks memory for nothing
    assert property (@(posedge clk) disable iff (reset_i)
        !seen_en |-> !fetch_o);

    // fetches stay inside the block as long as it was not reprogrammed
    assert property (@(posedge clk) disable iff (reset_i)
        (enable_i && take_word && len_i != '0 && start_i == start_q && len_i == len_q)
        |-> (addr_o - start_i) < {1'b0, len_i});

endmodule

`default_nettype wire

// ==== design/audio_dac.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "audio_defs.svh"

module audio_dac #(
    parameter int WIDTH = `AUDIO_DAC_W
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic [WIDTH-1:0]   value_i,        // unsigned level
    output logic                    pulse_o         // one-bit density output
);

    logic [WIDTH-1:0]   acc;
    logic [WIDTH:0]     sum;                        // carry on top

    assign sum = {1'b0, acc} + {1'b0, value_i};

    // first order sigma-delta, the carry rate tracks value_i / 2**WIDTH
    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc     <= '0;
            pulse_o <= 1'b0;
        end else begin
            acc     <= sum[WIDTH-1:0];
            pulse_o <= sum[WIDTH];
        end
    end

endmodule

`default_nettype wire

// ==== design/audio_ctrl_pkg.sv ====
`default_nettype none

package audio_ctrl_pkg;

    // mixer alternates between operand capture and result output
    typedef enum logic [1:0] {
        MIX_CAPTURE = 2'b00,        // register samples and volumes
        MIX_OUTPUT  = 2'b01         // multiply, sum, saturate, register levels
    } mix_state_e;

endpackage

`default_nettype wire

// ==== design/audio_data_pkg.sv ====
`default_nettype none

`include "audio_defs.svh"

package audio_data_pkg;

    // word address of a sample pair in external memory
    typedef logic [`AUDIO_ADDR_W-1:0] addr_t;

    // two samples, the first one played sits in the high byte
    typedef logic [`AUDIO_WORD_W-1:0] word_t;

    typedef logic signed [7:0] sample_t;            // signed sample or volume

    typedef logic [`AUDIO_DAC_W-1:0] level_t;       // unsigned DAC level, 0x80 is silence

endpackage

`default_nettype wire

// ==== design/audio_defs.svh ====
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

// sample memory addressing
`define AUDIO_ADDR_W    16      // word address into sample memory
`define AUDIO_WORD_W    16      // memory word, two packed samples

// block length counted in words, byte counter adds two bits
`define AUDIO_LEN_W     15

// resolution of the pulse-density DACs
`define AUDIO_DAC_W     8

`endif
